// File: Makefile
# Verilator build and run for the OPPM transmitter testbench

VERILATOR ?= verilator
TOP       ?= tb_oppm_tx
FILELIST  ?= build.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert

SOURCES := $(shell grep -v '^+' $(FILELIST))
HEADERS := $(wildcard *.svh)
SIM     := $(OBJ_DIR)/V$(TOP)

.PHONY: all run clean

all: run

# Rebuild only when a source, header or the file list changes
$(SIM): $(SOURCES) $(HEADERS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

# Fails unless the pass message is in the output
run: $(SIM)
	@out="$$(./$(SIM))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx 'TEST PASSED'

clean:
	rm -rf $(OBJ_DIR)

// File: build.f
+incdir+.
oppm_pkg.sv
oppm_slot_timer.sv
oppm_frame_seq.sv
oppm_pulse_gen.sv
oppm_tx.sv
tb_oppm_tx.sv

// File: oppm_cfg.svh
`ifndef OPPM_CFG_SVH
`define OPPM_CFG_SVH

// Symbol format
`define OPPM_MOD_BITS     2  // Bits carried by one symbol
`define OPPM_SLOT_TICKS   8  // Clock cycles per slot
`define OPPM_PULSE_TICKS  3  // Pulse width, no wider than a slot

// Frame format
`define OPPM_PKT_BITS     8  // Packet width
`define OPPM_PRE_SYMS     2  // Preamble symbols, always value 0

// Derived sizes
`define OPPM_DATA_SYMS ((`OPPM_PKT_BITS + `OPPM_MOD_BITS - 1) / `OPPM_MOD_BITS)
`define OPPM_SYM_CYCLES ((1 << `OPPM_MOD_BITS) * `OPPM_SLOT_TICKS)

// Counter widths
`define OPPM_TICK_BITS $clog2(`OPPM_SLOT_TICKS)
`define OPPM_PCNT_BITS $clog2(`OPPM_PULSE_TICKS)

// Wide enough for the longer of the two frame phases
`define OPPM_SCNT_BITS \
  $clog2(((`OPPM_PRE_SYMS > `OPPM_DATA_SYMS) ? `OPPM_PRE_SYMS : `OPPM_DATA_SYMS) + 1)

`endif

// File: oppm_frame_seq.sv
`timescale 1ns/100ps

`include "oppm_cfg.svh"

module oppm_frame_seq
  import oppm_pkg::*;
(
  input  logic    clk,
  input  logic    rst_n,
  input  logic    in_valid, // Packet offered
  input  pkt_t    in_data,
  output logic    in_ready, // Holding buffer empty
  input  logic    sym_end,  // Symbol boundary from timer
  output symbol_t cur_sym   // Symbol for the next period
);

  localparam sym_cnt_t PRE_LAST  = sym_cnt_t'(`OPPM_PRE_SYMS);
  localparam sym_cnt_t DATA_LAST = sym_cnt_t'(`OPPM_DATA_SYMS);

  // Holding buffer
  pkt_t buf_data;
  logic buf_full;
  logic accept;

  // Frame in flight
  pkt_t         shreg;     // Remaining data bits, MSB first
  frame_state_e state;
  sym_cnt_t     sym_cnt;   // Symbols already issued in this phase
  sym_t         data_sym;  // Top symbol of the shift register

  logic frame_done;
  logic load_frame;
  logic issue_data;

  assign in_ready = ~buf_full;
  assign accept   = in_valid & in_ready;
  assign data_sym = shreg[`OPPM_PKT_BITS-1 -: `OPPM_MOD_BITS];

  always_comb begin
    frame_done = (state == frame_data) && (sym_cnt == DATA_LAST);

    // New frame starts from idle, or right behind the previous one
    load_frame = sym_end && buf_full && ((state == frame_idle) || frame_done);

    // Preamble over, or more data symbols still to send
    issue_data = sym_end &&
                 (((state == frame_pream) && (sym_cnt == PRE_LAST)) ||
                  ((state == frame_data) && !frame_done));
  end

  // Buffer flag
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      buf_full <= 1'b0;
    end else if (accept) begin
      buf_full <= 1'b1;
    end else if (load_frame) begin
      buf_full <= 1'b0; // Packet moved into the shift register
    end
  end

  // Frame FSM, steps only on symbol boundaries
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state         <= frame_idle;
      sym_cnt       <= '0;
      cur_sym.valid <= 1'b0;
      cur_sym.value <= '0;
    end else if (sym_end) begin
      if (load_frame) begin
        state         <= frame_pream;
        sym_cnt       <= sym_cnt_t'(1);
        cur_sym.valid <= 1'b1;
        cur_sym.value <= '0; // First preamble symbol
      end else if (issue_data) begin
        state         <= frame_data;
        cur_sym.valid <= 1'b1;
        cur_sym.value <= data_sym;
        if (state == frame_pream) begin
          sym_cnt <= sym_cnt_t'(1);
        end else begin
          sym_cnt <= sym_cnt + sym_cnt_t'(1);
        end
      end else if (state == frame_pream) begin
        sym_cnt       <= sym_cnt + sym_cnt_t'(1);
        cur_sym.valid <= 1'b1;
        cur_sym.value <= '0;
      end else begin
        // Nothing waiting, the line goes quiet
        state         <= frame_idle;
        sym_cnt       <= '0;
        cur_sym.valid <= 1'b0;
        cur_sym.value <= '0;
      end
    end
  end

  // Packet storage
  always_ff @(posedge clk) begin
    if (accept) begin
      buf_data <= in_data;
    end
    if (load_frame) begin
      shreg <= buf_data;
    end else if (issue_data) begin
      shreg <= shreg << `OPPM_MOD_BITS; // Next symbol to the top
    end
  end

  // The source must hold its packet while stalled
  a_in_hold: assert property (
    @(posedge clk) disable iff (!rst_n)
    (in_valid && !in_ready) |=> $stable(in_data)
  ) else $error("in_data changed while stalled");

endmodule

// File: oppm_pkg.sv
`include "oppm_cfg.svh"

package oppm_pkg;

  // Plain vectors
  typedef logic [`OPPM_MOD_BITS-1:0]  sym_t;       // Symbol value or slot index
  typedef logic [`OPPM_TICK_BITS-1:0] tick_t;      // Tick inside a slot
  typedef logic [`OPPM_PKT_BITS-1:0]  pkt_t;       // One packet
  typedef logic [`OPPM_PCNT_BITS-1:0] pulse_cnt_t; // Remaining pulse cycles
  typedef logic [`OPPM_SCNT_BITS-1:0] sym_cnt_t;   // Symbols issued in a phase

  // Position of the timer within a symbol period
  typedef struct packed {
    sym_t  slot;
    tick_t tick;
  } slot_pos_t;

  // Symbol on air during the current period
  typedef struct packed {
    logic valid; // Low for an empty period
    sym_t value;
  } symbol_t;

  typedef enum logic [1:0] {
    frame_idle,
    frame_pream,
    frame_data
  } frame_state_e;

endpackage

// File: oppm_pulse_gen.sv
`timescale 1ns/100ps

`include "oppm_cfg.svh"

module oppm_pulse_gen
  import oppm_pkg::*;
(
  input  logic      clk,
  input  logic      rst_n,
  input  slot_pos_t slot_pos, // Position within the symbol period
  input  symbol_t   cur_sym,  // Symbol of this period
  output logic      pulse
);

  localparam pulse_cnt_t PULSE_LAST = pulse_cnt_t'(`OPPM_PULSE_TICKS - 1);

  pulse_cnt_t pulse_cnt; // Cycles left after the current one
  logic       start;

  // Fire at the opening tick of the slot named by the symbol
  always_comb begin
    start = cur_sym.valid &&
            (cur_sym.value == slot_pos.slot) &&
            (slot_pos.tick == '0);
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      pulse     <= 1'b0;
      pulse_cnt <= '0;
    end else if (start) begin
      pulse     <= 1'b1;
      pulse_cnt <= PULSE_LAST;
    end else if (pulse) begin
      if (pulse_cnt == '0) begin
        pulse <= 1'b0; // Width reached
      end else begin
        pulse_cnt <= pulse_cnt - pulse_cnt_t'(1);
      end
    end
  end

  // Pulses of neighbouring symbols never overlap when the width fits a slot
  a_no_overlap: assert property (
    @(posedge clk) disable iff (!rst_n)
    start |-> !pulse
  ) else $error("pulse start while previous pulse active");

endmodule

// File: oppm_slot_timer.sv
`timescale 1ns/100ps

`include "oppm_cfg.svh"

module oppm_slot_timer
  import oppm_pkg::*;
(
  input  logic      clk,
  input  logic      rst_n,
  output slot_pos_t slot_pos, // Current slot and tick
  output logic      sym_end   // Last tick of last slot
);

  localparam tick_t TICK_LAST = tick_t'(`OPPM_SLOT_TICKS - 1);
  localparam sym_t  SLOT_LAST = sym_t'((1 << `OPPM_MOD_BITS) - 1);

  tick_t tick;
  sym_t  slot;
  logic  tick_wrap;

  assign tick_wrap = (tick == TICK_LAST);

  // Tick counter, never stalls
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      tick <= '0;
    end else if (tick_wrap) begin
      tick <= '0;
    end else begin
      tick <= tick + tick_t'(1);
    end
  end

  // Slot counter steps at the end of each slot
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      slot <= '0;
    end else if (tick_wrap) begin
      if (slot == SLOT_LAST) begin
        slot <= '0;
      end else begin
        slot <= slot + sym_t'(1);
      end
    end
  end

  always_comb begin
    slot_pos.slot = slot;
    slot_pos.tick = tick;
    sym_end       = tick_wrap && (slot == SLOT_LAST);
  end

  // A tick past the slot end would shift every pulse position
  a_tick_range: assert property (
    @(posedge clk) disable iff (!rst_n)
    tick <= TICK_LAST
  ) else $error("slot tick %0d out of range", tick);

endmodule

// File: oppm_tx.sv
`timescale 1ns/100ps

`include "oppm_cfg.svh"

module oppm_tx
  import oppm_pkg::*;
(
  input  logic clk,
  input  logic rst_n,
  input  logic in_valid, // Packet offered
  input  pkt_t in_data,
  output logic in_ready, // Packet can be taken
  output logic pulse     // OPPM line
);

  slot_pos_t slot_pos;
  logic      sym_end;
  symbol_t   cur_sym;

  // Intake and symbol sequencing
  oppm_frame_seq u_seq (
    .clk      (clk),
    .rst_n    (rst_n),
    .in_valid (in_valid),
    .in_data  (in_data),
    .in_ready (in_ready),
    .sym_end  (sym_end),
    .cur_sym  (cur_sym)
  );

  // Slot and symbol timing
  oppm_slot_timer u_timer (
    .clk      (clk),
    .rst_n    (rst_n),
    .slot_pos (slot_pos),
    .sym_end  (sym_end)
  );

  // Line driver
  oppm_pulse_gen u_pulse (
    .clk      (clk),
    .rst_n    (rst_n),
    .slot_pos (slot_pos),
    .cur_sym  (cur_sym),
    .pulse    (pulse)
  );

endmodule

// File: tb_oppm_tx.sv
`timescale 1ns/100ps

`include "oppm_cfg.svh"

module tb_oppm_tx
  import oppm_pkg::*;
();

  localparam int CLK_PERIOD       = 4;
  localparam int RESET_CYCLES     = 5;
  localparam int SYM_CYCLES       = `OPPM_SYM_CYCLES;
  localparam int SLOT_TICKS       = `OPPM_SLOT_TICKS;
  localparam int PRE_SYMS         = `OPPM_PRE_SYMS;
  localparam int FRAME_SYMS       = `OPPM_PRE_SYMS + `OPPM_DATA_SYMS;
  localparam int NUM_RAND_PKTS    = 12;
  localparam int TOTAL_PKTS       = NUM_RAND_PKTS + 2; // Two directed packets first
  localparam int IDLE_PERIODS     = 3;
  localparam int LONG_GAP_PERIODS = 3;
  localparam logic [31:0] LFSR_SEED = 32'd91606;
  localparam logic [31:0] LFSR_TAPS = 32'h80200003; // x^32 + x^22 + x^2 + x + 1
  localparam int WATCH_MARGIN_NS  = 16 * SYM_CYCLES * CLK_PERIOD;
  localparam int WATCH_NS = TOTAL_PKTS * (FRAME_SYMS + 2) * SYM_CYCLES * CLK_PERIOD +
                            WATCH_MARGIN_NS;

  logic clk;
  logic rst_n;
  logic in_valid;
  pkt_t in_data;
  logic in_ready;
  logic pulse;

  logic        quiet_check; // No frame may start while high
  logic [31:0] lfsr;
  pkt_t        sent_q[$];   // Accepted packets in order
  int          frame_ref[$]; // Reference rise cycle of each frame

  // Pulse decoder state
  int   cyc;
  logic pulse_d;
  int   high_len;
  int   rise_idx;   // Pulses seen in the current frame
  int   ref_cyc;
  pkt_t data_acc;
  int   frames_done;
  int   total_rises;
  int   stall_cycles;

  int mon_mismatch  = 0;
  int mon_other     = 0;
  int stim_mismatch = 0;
  int stim_other    = 0;
  int fill_fail     = 0;
  int quiet_fail    = 0;
  int timed_out     = 0;

  oppm_tx u_dut (
    .clk      (clk),
    .rst_n    (rst_n),
    .in_valid (in_valid),
    .in_data  (in_data),
    .in_ready (in_ready),
    .pulse    (pulse)
  );

  initial begin
    clk = 1'b0;
    forever #(CLK_PERIOD / 2) clk = ~clk;
  end

  function automatic logic rand_bit();
    logic out;
    out  = lfsr[0];
    lfsr = lfsr >> 1;
    if (out) begin
      lfsr = lfsr ^ LFSR_TAPS;
    end
    return out;
  endfunction

  function automatic int unsigned rand_bits(input int n);
    int unsigned val;
    val = 0;
    for (int i = 0; i < n; i++) begin
      val = (val << 1) | {31'd0, rand_bit()};
    end
    return val;
  endfunction

  task automatic idle_cycles(input int n);
    repeat (n) @(posedge clk);
  endtask

  // Offer one packet and hold it until the DUT takes it
  task automatic send_packet(input pkt_t data);
    in_valid <= 1'b1;
    in_data  <= data;
    @(posedge clk);
    while (!in_ready) begin
      @(posedge clk);
    end
    sent_q.push_back(data);
  endtask

  task automatic wait_frames(input int count);
    while (frames_done < count) begin
      @(posedge clk);
    end
  endtask

  task automatic report_result();
    int mismatches;
    int others;
    mismatches = mon_mismatch + stim_mismatch + fill_fail + quiet_fail;
    others     = mon_other + stim_other + timed_out;
    $display("Errors: %0d mismatches, %0d other failures, %0d of %0d frames decoded",
             mismatches, others, frames_done, TOTAL_PKTS);
    if (mismatches == 0 && others == 0) begin
      $display("TEST PASSED");
    end else begin
      $display("TEST FAILED");
    end
    $finish;
  endtask

  // Decode pulse positions back into symbols and packets
  always @(posedge clk) begin : pulse_monitor
    int   off;
    int   k;
    int   v;
    pkt_t rebuilt;
    if (!rst_n) begin
      cyc         <= 0;
      pulse_d     <= 1'b0;
      high_len    <= 0;
      rise_idx    <= 0;
      ref_cyc     <= 0;
      data_acc    <= '0;
      frames_done <= 0;
      total_rises <= 0;
    end else begin
      cyc     <= cyc + 1;
      pulse_d <= pulse;
      if (pulse) begin
        high_len <= high_len + 1;
      end else if (pulse_d) begin
        assert (high_len == `OPPM_PULSE_TICKS) else begin
          mon_mismatch++;
          $display("MISMATCH at %0t: pulse lasted %0d cycles, expected %0d",
                   $time, high_len, `OPPM_PULSE_TICKS);
        end
        high_len <= 0;
      end
      if (pulse && !pulse_d) begin
        total_rises <= total_rises + 1;
        if (rise_idx == 0) begin
          frame_ref.push_back(cyc); // First preamble pulse
          ref_cyc  <= cyc;
          data_acc <= '0;
          rise_idx <= 1;
        end else begin
          off = cyc - ref_cyc;
          k   = off / SYM_CYCLES;
          v   = (off % SYM_CYCLES) / SLOT_TICKS;
          assert (k == rise_idx && (off % SLOT_TICKS) == 0) else begin
            mon_mismatch++;
            $display("MISMATCH at %0t: pulse %0d of frame %0d at offset %0d, expected period %0d",
                     $time, rise_idx, frames_done, off, rise_idx);
          end
          if (rise_idx < PRE_SYMS) begin
            assert (v == 0) else begin
              mon_mismatch++;
              $display("MISMATCH at %0t: preamble symbol decoded as %0d, expected 0",
                       $time, v);
            end
          end
          rebuilt = (data_acc << `OPPM_MOD_BITS) | pkt_t'(v);
          if (rise_idx >= PRE_SYMS) begin
            data_acc <= rebuilt;
          end
          if (rise_idx == FRAME_SYMS - 1) begin
            if (frames_done < sent_q.size()) begin
              assert (rebuilt == sent_q[frames_done]) else begin
                mon_mismatch++;
                $display("MISMATCH at %0t: frame %0d decoded 0x%02h, expected 0x%02h",
                         $time, frames_done, rebuilt, sent_q[frames_done]);
              end
            end else begin
              mon_other++;
              $display("Frame %0d was sent with no packet accepted for it", frames_done);
            end
            frames_done <= frames_done + 1;
            rise_idx    <= 0;
          end else begin
            rise_idx <= rise_idx + 1;
          end
        end
      end
    end
  end

  always @(posedge clk) begin
    if (!rst_n) begin
      stall_cycles <= 0;
    end else if (in_valid && !in_ready) begin
      stall_cycles <= stall_cycles + 1;
    end
  end

  // Holding buffer is full right after a transfer
  a_ready_drops: assert property (
    @(posedge clk) disable iff (!rst_n)
    (in_valid && in_ready) |=> !in_ready
  ) else begin
    fill_fail++;
    $display("MISMATCH at %0t: in_ready still high after a transfer", $time);
  end

  a_quiet_line: assert property (
    @(posedge clk) disable iff (!rst_n)
    quiet_check |-> !$rose(pulse)
  ) else begin
    quiet_fail++;
    $display("MISMATCH at %0t: pulse rose while no frame was due", $time);
  end

  initial begin : main_seq
    pkt_t data;
    int   gap;
    int   stall_before;
    int   b2b_idx;
    lfsr = LFSR_SEED;
    rst_n       <= 1'b0;
    in_valid    <= 1'b0;
    in_data     <= '0;
    quiet_check <= 1'b0;
    repeat (RESET_CYCLES) @(posedge clk);
    rst_n <= 1'b1;
    @(posedge clk);
    assert (in_ready === 1'b1 && pulse === 1'b0) else begin
      stim_mismatch++;
      $display("MISMATCH at %0t: after reset in_ready=%b pulse=%b, expected 1 and 0",
               $time, in_ready, pulse);
    end

    // Idle line with nothing offered
    quiet_check <= 1'b1;
    idle_cycles(IDLE_PERIODS * SYM_CYCLES);
    quiet_check <= 1'b0;

    // Two packets back to back, all four symbol values each
    b2b_idx      = sent_q.size();
    stall_before = stall_cycles;
    send_packet(8'h1B);
    send_packet(8'hE4);
    in_valid <= 1'b0;
    assert (stall_cycles > stall_before) else begin
      stim_mismatch++;
      $display("MISMATCH at %0t: in_ready never dropped with a packet waiting", $time);
    end
    wait_frames(b2b_idx + 2);
    gap = frame_ref[b2b_idx + 1] - frame_ref[b2b_idx];
    assert (gap == FRAME_SYMS * SYM_CYCLES) else begin
      stim_mismatch++;
      $display("MISMATCH at %0t: back-to-back frames %0d cycles apart, expected %0d",
               $time, gap, FRAME_SYMS * SYM_CYCLES);
    end

    // Random packets with random gaps
    for (int n = 0; n < NUM_RAND_PKTS; n++) begin
      data = pkt_t'(rand_bits(`OPPM_PKT_BITS));
      send_packet(data);
      in_valid <= 1'b0;
      if (rand_bits(2) == 0) begin
        gap = LONG_GAP_PERIODS * SYM_CYCLES; // Lets the line go idle
      end else begin
        gap = int'(rand_bits(4));
      end
      idle_cycles(gap);
    end

    wait_frames(TOTAL_PKTS);
    quiet_check <= 1'b1;
    idle_cycles(IDLE_PERIODS * SYM_CYCLES);
    quiet_check <= 1'b0;

    assert (rise_idx == 0) else begin
      stim_other++;
      $display("A frame stopped after %0d of %0d pulses", rise_idx, FRAME_SYMS);
    end
    assert (total_rises == TOTAL_PKTS * FRAME_SYMS) else begin
      stim_mismatch++;
      $display("MISMATCH at %0t: %0d pulses in total, expected %0d",
               $time, total_rises, TOTAL_PKTS * FRAME_SYMS);
    end
    report_result();
  end

  initial begin : watchdog
    #(WATCH_NS);
    timed_out = 1;
    $display("Timeout after %0d ns with %0d of %0d frames decoded",
             WATCH_NS, frames_done, TOTAL_PKTS);
    report_result();
  end

endmodule
